// ==== design/engine_filter_params.svh ====
// Packet geometry and counter width macros for the filter engine
`ifndef ENGINE_FILTER_PARAMS_SVH
`define ENGINE_FILTER_PARAMS_SVH

// Fields carried by one memory packet
`define NUM_FIELDS 4

// Bits per packet field
`define FIELD_WIDTH 32

// Pass and drop counter width
`define COUNT_WIDTH 16

`endif

// ==== design/engine_packet_pkg.sv ====
// Packet field, packet word and counter types
`include "engine_filter_params.svh"

package engine_packet_pkg;

  // ------------------------------------------------
  // Scalar widths
  // ------------------------------------------------

  // One packet field
  typedef logic [`FIELD_WIDTH-1:0] field_t;

  // Pass and drop counters
  typedef logic [`COUNT_WIDTH-1:0] count_t;

  // ------------------------------------------------
  // Packet word
  // ------------------------------------------------

  // Field 0 sits in the low bits
  typedef struct packed {
    field_t [`NUM_FIELDS-1:0] field;
  } packet_t;

endpackage : engine_packet_pkg

// ==== design/filter_cfg_pkg.sv ====
// Filter and combine opcodes, mask types, configuration and kernel result structs
`include "engine_filter_params.svh"

package filter_cfg_pkg;

  import engine_packet_pkg::*;

  // One bit per field slot
  typedef logic [`NUM_FIELDS-1:0] field_mask_t;

  // ------------------------------------------------
  // Operation codes
  // ------------------------------------------------

  // Codes above FILTER_NE_TERN are undefined
  typedef enum logic [3:0] {
    FILTER_NOP     = 4'd0,
    FILTER_GT      = 4'd1,
    FILTER_LT      = 4'd2,
    FILTER_EQ      = 4'd3,
    FILTER_NE      = 4'd4,
    FILTER_GT_TERN = 4'd5,
    FILTER_LT_TERN = 4'd6,
    FILTER_EQ_TERN = 4'd7,
    FILTER_NE_TERN = 4'd8
  } filter_op_e;

  typedef enum logic [1:0] {
    COMBINE_AND     = 2'd0,
    COMBINE_OR      = 2'd1,
    COMBINE_PRIMARY = 2'd2
  } combine_op_e;

  // ------------------------------------------------
  // Kernel configuration and result
  // ------------------------------------------------

  // Row i of ops_mask picks the source field of operand slot i
  typedef struct packed {
    filter_op_e                    filter_op;
    field_mask_t                   const_mask;
    field_t                        const_value;
    field_mask_t [`NUM_FIELDS-1:0] ops_mask;
    field_mask_t                   filter_mask;
  } filter_cfg_t;

  typedef struct packed {
    logic    valid;
    logic    flag;
    packet_t data;
  } kernel_result_t;

endpackage : filter_cfg_pkg

// ==== design/filter_cond_kernel.sv ====
// Two-stage filter condition kernel: operand select, then condition evaluate
`timescale 1ns/1ps
`include "engine_filter_params.svh"

module filter_cond_kernel (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           clear,
  input  logic                           config_valid,
  input  filter_cfg_pkg::filter_cfg_t    cfg,
  input  logic                           in_valid,
  input  engine_packet_pkg::packet_t     in_data,
  output filter_cfg_pkg::kernel_result_t result
);

  import engine_packet_pkg::*;
  import filter_cfg_pkg::*;

  logic    accept;
  packet_t ops_vec;
  logic    ops_mask_ok;

  // Stage 1 registers
  logic    s1_valid;
  packet_t s1_ops;
  packet_t s1_org;

  // Stage 2 evaluation
  logic    sel_hit;
  field_t  op_a;
  field_t  op_b;
  logic    cond;
  logic    res_flag;
  packet_t res_data;

  // ------------------------------------------------
  // Stage 1: operand vector
  // ------------------------------------------------

  assign accept = in_valid & config_valid;

  // Constant wins over the field mask, highest mask bit wins among fields
  always_comb begin
    ops_vec = '0;
    for (int i = 0; i < `NUM_FIELDS; i++) begin
      if (cfg.const_mask[i]) begin
        ops_vec.field[i] = cfg.const_value;
      end else begin
        for (int j = 0; j < `NUM_FIELDS; j++) begin
          if (cfg.ops_mask[i][j]) begin
            ops_vec.field[i] = in_data.field[j];
          end
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
    end
    if (accept) begin
      s1_ops <= ops_vec;
      s1_org <= in_data;
    end
  end

  // ------------------------------------------------
  // Stage 2: condition and result
  // ------------------------------------------------

  // Select index is the highest filter_mask bit below the last slot
  always_comb begin
    sel_hit = 1'b0;
    op_a    = '0;
    op_b    = '0;
    for (int i = 0; i < `NUM_FIELDS - 1; i++) begin
      if (cfg.filter_mask[i]) begin
        sel_hit = 1'b1;
        op_a    = s1_ops.field[i];
        op_b    = s1_ops.field[i + 1];
      end
    end
  end

  always_comb begin
    case (cfg.filter_op)
      FILTER_GT, FILTER_GT_TERN: cond = (op_a > op_b);
      FILTER_LT, FILTER_LT_TERN: cond = (op_a < op_b);
      FILTER_EQ, FILTER_EQ_TERN: cond = (op_a == op_b);
      FILTER_NE, FILTER_NE_TERN: cond = (op_a != op_b);
      default:                   cond = 1'b0;
    endcase
  end

  always_comb begin
    res_flag = 1'b1;
    res_data = s1_org;
    case (cfg.filter_op)
      FILTER_NOP: begin
        res_flag = 1'b1;
      end
      FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NE: begin
        // No select bit means the packet passes
        if (sel_hit) begin
          res_flag = cond;
        end
      end
      FILTER_GT_TERN, FILTER_LT_TERN, FILTER_EQ_TERN, FILTER_NE_TERN: begin
        // Field 0 takes slot i on a true condition, else slot i+1
        if (sel_hit) begin
          res_data.field[0] = cond ? op_a : op_b;
        end
      end
      default: begin
        res_data = '0;
      end
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= s1_valid;
    end
    if (s1_valid) begin
      result.flag <= res_flag;
      result.data <= res_data;
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  always_comb begin
    ops_mask_ok = 1'b1;
    for (int i = 0; i < `NUM_FIELDS; i++) begin
      if ((cfg.ops_mask[i] & (cfg.ops_mask[i] - 1'b1)) != '0) begin
        ops_mask_ok = 1'b0;
      end
    end
  end

  // Operand selection assumes at most one source field per slot
  ops_mask_onehot_a : assert property (
    @(posedge ap_clk) disable iff (areset) accept |-> ops_mask_ok
  ) else $error("kernel accepted a packet with a multi-bit ops_mask row");

endmodule : filter_cond_kernel

// ==== design/filter_cond_combine.sv ====
// Combine stage: joins two kernel flags, registers the output, counts pass and drop
`timescale 1ns/1ps

module filter_cond_combine (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           clear,
  input  filter_cfg_pkg::combine_op_e    combine_op,
  input  filter_cfg_pkg::kernel_result_t primary,
  input  filter_cfg_pkg::kernel_result_t secondary,
  output logic                           out_valid,
  output logic                           out_flag,
  output engine_packet_pkg::packet_t     out_data,
  output engine_packet_pkg::count_t      pass_count,
  output engine_packet_pkg::count_t      drop_count
);

  import filter_cfg_pkg::*;

  logic joined_flag;

  // ------------------------------------------------
  // Flag join
  // ------------------------------------------------

  // Unused code falls back to the primary flag
  always_comb begin
    case (combine_op)
      COMBINE_AND: joined_flag = primary.flag & secondary.flag;
      COMBINE_OR:  joined_flag = primary.flag | secondary.flag;
      default:     joined_flag = primary.flag;
    endcase
  end

  // ------------------------------------------------
  // Output register and counters
  // ------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      out_valid  <= 1'b0;
      out_flag   <= 1'b0;
      out_data   <= '0;
      pass_count <= '0;
      drop_count <= '0;
    end else begin
      out_valid <= primary.valid;
      if (primary.valid) begin
        out_flag <= joined_flag;
        out_data <= primary.data;
        if (joined_flag) begin
          pass_count <= pass_count + 1'b1;
        end else begin
          drop_count <= drop_count + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // Both kernels see the same strobe and pipeline depth
  kernel_valid_match_a : assert property (
    @(posedge ap_clk) disable iff (areset) primary.valid == secondary.valid
  ) else $error("primary and secondary kernel valids disagree");

endmodule : filter_cond_combine

// ==== design/engine_filter_cond.sv ====
// Filter condition engine top: primary and secondary kernels feeding the combine stage
`timescale 1ns/1ps

module engine_filter_cond (
  input  logic                        ap_clk,
  input  logic                        areset,
  input  logic                        clear,
  input  logic                        config_valid,
  input  filter_cfg_pkg::filter_cfg_t cfg_primary,
  input  filter_cfg_pkg::filter_cfg_t cfg_secondary,
  input  filter_cfg_pkg::combine_op_e combine_op,
  input  logic                        in_valid,
  input  engine_packet_pkg::packet_t  in_data,
  output logic                        out_valid,
  output logic                        out_flag,
  output engine_packet_pkg::packet_t  out_data,
  output engine_packet_pkg::count_t   pass_count,
  output engine_packet_pkg::count_t   drop_count
);

  import filter_cfg_pkg::*;

  kernel_result_t res_primary;
  kernel_result_t res_secondary;

  // Both kernels test the same packet side by side
  filter_cond_kernel u_kernel_primary (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .clear        (clear),
    .config_valid (config_valid),
    .cfg          (cfg_primary),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .result       (res_primary)
  );

  filter_cond_kernel u_kernel_secondary (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .clear        (clear),
    .config_valid (config_valid),
    .cfg          (cfg_secondary),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .result       (res_secondary)
  );

  // Output data always comes from the primary kernel
  filter_cond_combine u_combine (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .combine_op (combine_op),
    .primary    (res_primary),
    .secondary  (res_secondary),
    .out_valid  (out_valid),
    .out_flag   (out_flag),
    .out_data   (out_data),
    .pass_count (pass_count),
    .drop_count (drop_count)
  );

endmodule : engine_filter_cond

// ==== sim/tb_engine_filter_cond.sv ====
// Filter engine testbench with stimulus, LCG, reference model, expected queue and checker
`timescale 1ns/1ps
`include "engine_filter_params.svh"

module tb_engine_filter_cond;

  import engine_packet_pkg::*;
  import filter_cfg_pkg::*;

  logic           ap_clk;
  logic           areset;
  logic           clear;
  logic           config_valid;
  filter_cfg_t    cfg_primary;
  filter_cfg_t    cfg_secondary;
  combine_op_e    combine_op;
  logic           in_valid;
  packet_t        in_data;
  logic           out_valid;
  logic           out_flag;
  packet_t        out_data;
  count_t         pass_count;
  count_t         drop_count;

  logic [31:0]    rng_state = 32'h242e;
  int             cyc = 0;
  int             errors = 0;
  int             pass_tally = 0;
  int             drop_tally = 0;
  string          test_name = "reset";
  kernel_result_t exp_q[$];
  int             due_q[$];

  engine_filter_cond i_engine_filter_cond (.*);

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  always @(posedge ap_clk) begin
    cyc <= cyc + 1;
  end

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Narrow packets keep values small so equal operands are common
  function automatic packet_t random_packet(input logic narrow);
    packet_t pkt;
    for (int i = 0; i < `NUM_FIELDS; i++) begin
      pkt.field[i] = narrow ? (next_random() >> 29) : next_random();
    end
    return pkt;
  endfunction

  // Slot i reads field (i + rot) and the compare sits at slot sel
  function automatic filter_cfg_t field_cfg(input filter_op_e op, input int rot, input int sel);
    filter_cfg_t cfg;
    cfg = '0;
    cfg.filter_op = op;
    for (int i = 0; i < `NUM_FIELDS; i++) begin
      cfg.ops_mask[i] = field_mask_t'(1) << ((i + rot) % `NUM_FIELDS);
    end
    cfg.filter_mask = field_mask_t'(1) << sel;
    return cfg;
  endfunction

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------

  function automatic kernel_result_t kernel_model(input filter_cfg_t cfg, input packet_t pkt);
    kernel_result_t res;
    field_t         ops [`NUM_FIELDS];
    int             sel;
    logic           cond;
    res.valid = 1'b1;
    res.flag  = 1'b1;
    res.data  = pkt;
    sel       = -1;
    cond      = 1'b0;
    for (int i = 0; i < `NUM_FIELDS; i++) begin
      ops[i] = '0;
      for (int j = `NUM_FIELDS - 1; j >= 0; j--) begin
        if (cfg.ops_mask[i][j]) begin
          ops[i] = pkt.field[j];
          break;
        end
      end
      if (cfg.const_mask[i]) begin
        ops[i] = cfg.const_value;
      end
    end
    for (int i = `NUM_FIELDS - 2; i >= 0; i--) begin
      if (cfg.filter_mask[i] && sel < 0) begin
        sel = i;
      end
    end
    if (sel >= 0) begin
      case (cfg.filter_op)
        FILTER_GT, FILTER_GT_TERN: cond = ops[sel] > ops[sel + 1];
        FILTER_LT, FILTER_LT_TERN: cond = ops[sel] < ops[sel + 1];
        FILTER_EQ, FILTER_EQ_TERN: cond = ops[sel] == ops[sel + 1];
        FILTER_NE, FILTER_NE_TERN: cond = ops[sel] != ops[sel + 1];
        default:                   cond = 1'b1;
      endcase
    end
    if (cfg.filter_op inside {FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NE}) begin
      if (sel >= 0) begin
        res.flag = cond;
      end
    end else if (cfg.filter_op inside {FILTER_GT_TERN, FILTER_LT_TERN,
                                       FILTER_EQ_TERN, FILTER_NE_TERN}) begin
      if (sel >= 0) begin
        res.data.field[0] = cond ? ops[sel] : ops[sel + 1];
      end
    end else if (cfg.filter_op != FILTER_NOP) begin
      res.data = '0;
    end
    return res;
  endfunction

  function automatic kernel_result_t expected_output(input filter_cfg_t p_cfg,
      input filter_cfg_t s_cfg, input combine_op_e op, input packet_t pkt);
    kernel_result_t p_res;
    kernel_result_t s_res;
    p_res = kernel_model(p_cfg, pkt);
    s_res = kernel_model(s_cfg, pkt);
    if (op == COMBINE_AND) begin
      p_res.flag = p_res.flag & s_res.flag;
    end else if (op == COMBINE_OR) begin
      p_res.flag = p_res.flag | s_res.flag;
    end
    return p_res;
  endfunction

  // ------------------------------------------------
  // Driver tasks
  // ------------------------------------------------

  task automatic set_config(input filter_cfg_t p_cfg, input filter_cfg_t s_cfg,
      input combine_op_e op, input string name);
    @(posedge ap_clk);
    cfg_primary   <= p_cfg;
    cfg_secondary <= s_cfg;
    combine_op    <= op;
    test_name      = name;
  endtask

  task automatic send_packet(input packet_t pkt);
    kernel_result_t exp;
    @(posedge ap_clk);
    in_valid <= 1'b1;
    in_data  <= pkt;
    if (config_valid) begin
      exp = expected_output(cfg_primary, cfg_secondary, combine_op, pkt);
      exp_q.push_back(exp);
      // cyc still holds the count before this edge
      due_q.push_back(cyc + 4);
      if (exp.flag) begin
        pass_tally++;
      end else begin
        drop_tally++;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 50) begin
      @(posedge ap_clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("Timed out in %s with %0d outputs missing", test_name, exp_q.size());
      errors++;
      exp_q.delete();
      due_q.delete();
    end
  endtask

  // Back-to-back packets and then idle until all outputs are seen
  task automatic run_burst(input int count);
    for (int k = 0; k < count; k++) begin
      send_packet(random_packet(k % 2 == 1));
    end
    @(posedge ap_clk);
    in_valid <= 1'b0;
    wait_drain();
  endtask

  task automatic check_counters();
    @(negedge ap_clk);
    if (pass_count !== count_t'(pass_tally)) begin
      $display("FAILED %s pass_count: expected %0d, actual %0d",
               test_name, pass_tally, pass_count);
      errors++;
    end
    if (drop_count !== count_t'(drop_tally)) begin
      $display("FAILED %s drop_count: expected %0d, actual %0d",
               test_name, drop_tally, drop_count);
      errors++;
    end
  endtask

  // ------------------------------------------------
  // Output checker
  // ------------------------------------------------

  always @(negedge ap_clk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected output in %s at cycle %0d", test_name, cyc);
        errors++;
      end else begin
        if (due_q[0] != cyc) begin
          $display("FAILED %s timing: expected cycle %0d, actual cycle %0d",
                   test_name, due_q[0], cyc);
          errors++;
        end
        if (out_flag !== exp_q[0].flag) begin
          $display("FAILED %s flag: expected %b, actual %b", test_name, exp_q[0].flag, out_flag);
          errors++;
        end
        if (out_data !== exp_q[0].data) begin
          $display("FAILED %s data: expected %h, actual %h", test_name, exp_q[0].data, out_data);
          errors++;
        end
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
      $display("Missing output in %s, due at cycle %0d", test_name, due_q[0]);
      errors++;
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin
    filter_op_e  cmp_ops [4];
    filter_op_e  tern_ops [4];
    combine_op_e comb_ops [3];
    filter_cfg_t p_cfg;
    filter_cfg_t s_nop;
    cmp_ops       = '{FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NE};
    tern_ops      = '{FILTER_GT_TERN, FILTER_LT_TERN, FILTER_EQ_TERN, FILTER_NE_TERN};
    comb_ops      = '{COMBINE_AND, COMBINE_OR, COMBINE_PRIMARY};
    s_nop         = field_cfg(FILTER_NOP, 0, 0);
    areset        = 1'b1;
    clear         = 1'b0;
    config_valid  = 1'b0;
    cfg_primary   = '0;
    cfg_secondary = '0;
    combine_op    = COMBINE_PRIMARY;
    in_valid      = 1'b0;
    in_data       = '0;
    repeat (2) @(posedge ap_clk);
    areset <= 1'b0;

    // Reset state and then strobes with config_valid low
    @(negedge ap_clk);
    if (out_valid !== 1'b0 || out_flag !== 1'b0 || out_data !== '0) begin
      $display("FAILED reset: expected all 0, actual valid %b flag %b data %h",
               out_valid, out_flag, out_data);
      errors++;
    end
    check_counters();
    test_name = "config_valid low";
    run_burst(6);
    repeat (4) @(posedge ap_clk);
    check_counters();
    @(posedge ap_clk);
    config_valid <= 1'b1;

    for (int n = 0; n < 4; n++) begin
      set_config(field_cfg(cmp_ops[n], n, n % 3), s_nop, COMBINE_PRIMARY,
                 $sformatf("compare %s", cmp_ops[n].name()));
      run_burst(8);
    end

    // Constant operand in slot 2
    p_cfg             = field_cfg(FILTER_GT, 1, 1);
    p_cfg.const_mask  = 4'b0100;
    p_cfg.const_value = 32'h8000_0000;
    set_config(p_cfg, s_nop, COMBINE_PRIMARY, "const GT");
    run_burst(8);
    p_cfg.filter_op   = FILTER_EQ;
    p_cfg.const_value = 32'd3;
    set_config(p_cfg, s_nop, COMBINE_PRIMARY, "const EQ");
    run_burst(8);

    for (int n = 0; n < 4; n++) begin
      set_config(field_cfg(tern_ops[n], n + 1, n % 3), s_nop, COMBINE_PRIMARY,
                 $sformatf("ternary %s", tern_ops[n].name()));
      run_burst(6);
    end
    set_config(s_nop, s_nop, COMBINE_PRIMARY, "nop");
    run_burst(4);
    set_config(field_cfg(filter_op_e'(4'd12), 0, 0), s_nop, COMBINE_PRIMARY, "undefined op");
    run_burst(4);
    p_cfg             = field_cfg(FILTER_GT, 0, 0);
    p_cfg.filter_mask = 4'b1000;
    set_config(p_cfg, s_nop, COMBINE_PRIMARY, "no select bit");
    run_burst(4);

    // Secondary compares fields 2 and 3, apart from the primary's fields 0 and 1
    for (int n = 0; n < 3; n++) begin
      set_config(field_cfg(FILTER_GT, 0, 0), field_cfg(cmp_ops[n + 1], 1, 1), comb_ops[n],
                 $sformatf("combine %s", comb_ops[n].name()));
      run_burst(10);
    end
    check_counters();

    // Clear lands while two packets are in flight
    test_name = "clear";
    send_packet(random_packet(1'b0));
    send_packet(random_packet(1'b0));
    clear <= 1'b1;
    exp_q.delete();
    due_q.delete();
    pass_tally = 0;
    drop_tally = 0;
    @(posedge ap_clk);
    clear    <= 1'b0;
    in_valid <= 1'b0;
    repeat (5) @(posedge ap_clk);
    check_counters();
    test_name = "after clear";
    run_burst(6);
    check_counters();

    $display("Errors: %0d, passed outputs %0d, dropped outputs %0d",
             errors, pass_tally, drop_tally);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_engine_filter_cond

// ==== flist.f ====
+incdir+design
design/engine_packet_pkg.sv
design/filter_cfg_pkg.sv
design/filter_cond_kernel.sv
design/filter_cond_combine.sv
design/engine_filter_cond.sv
sim/tb_engine_filter_cond.sv
